// ==== hdl/div_pkg.sv ====
/*
 * Divide unit definitions
 * Instruction layout, function codes, fault causes and the record
 * passed from the issue stage to the result stage.
 */

package div_pkg;

	// ==================================================
	// Instruction word
	// ==================================================

	// Decoded instruction as seen by the divide lane, opcode in the top bits
	typedef struct packed {
		logic [6:0] opcode;
		// Set when the divisor comes from the immediate field
		logic       imm_sel;
		logic [2:0] op3;
		// Not looked at by this unit
		logic [4:0] rsvd;
	} div_instr_t;

	// Opcode of the divide group
	localparam logic [6:0] OP_DIV = 7'h1c;

	// Function codes, bit 2 selects the remainder and bit 0 marks unsigned
	localparam logic [2:0] FN_DIV  = 3'd0;
	localparam logic [2:0] FN_DIVU = 3'd1;
	localparam logic [2:0] FN_REM  = 3'd4;
	localparam logic [2:0] FN_REMU = 3'd5;

	// ==================================================
	// Results
	// ==================================================

	// Fault cause reported alongside each result
	typedef enum logic [1:0] {
		FLT_NONE  = 2'd0,
		FLT_DBZ   = 2'd1,
		FLT_UNIMP = 2'd2
	} cause_t;

	// Decoded operation held by the issue stage until the result is written
	typedef struct packed {
		logic want_rem;
		logic legal;
		logic is_div;
	} div_op_t;

	// Filler returned for an opcode outside the divide group
	localparam logic [15:0] FILL16 = 16'hdead;

endpackage

// ==== hdl/div_issue.sv ====
/*
 * Divide issue stage
 * Decodes the instruction, picks the divisor and captures the operands
 * on an accepted load, then starts the divider and tracks busy.
 */

`timescale 1ns/1ps

module div_issue #(
	parameter int WID = 32
) (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                ld,
	input  div_pkg::div_instr_t ir,
	input  logic [WID-1:0]      a,
	input  logic [WID-1:0]      b,
	input  logic [WID-1:0]      imm,
	input  logic                core_done,
	output logic                start,
	output logic                signed_op,
	output logic [WID-1:0]      dividend,
	output logic [WID-1:0]      divisor,
	output div_pkg::div_op_t    op,
	output logic                busy
);

	// A load counts only while the unit is idle
	logic             accept;
	div_pkg::div_op_t dec_op;

	assign accept = ld & ~busy;

	// ==================================================
	// Decode
	// ==================================================
	always_comb
	begin
		dec_op.is_div = (ir.opcode == div_pkg::OP_DIV);
		dec_op.want_rem = ir.op3[2];
		case (ir.op3)
		div_pkg::FN_DIV, div_pkg::FN_DIVU, div_pkg::FN_REM, div_pkg::FN_REMU:
			dec_op.legal = 1'b1;
		default:
			dec_op.legal = 1'b0;
		endcase
	end

	// Start pulses for one cycle after the accepted load; busy holds until the core is done
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			start <= 1'b0;
			busy <= 1'b0;
		end
		else
		begin
			start <= accept;
			if (accept)
				busy <= 1'b1;
			else if (core_done)
				busy <= 1'b0;
		end
	end

	// Operands and decoded op stay put for the whole run
	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			dividend <= a;
			divisor <= ir.imm_sel ? imm : b;
			// Odd function codes are the unsigned forms
			signed_op <= ~ir.op3[0];
			op <= dec_op;
		end
	end

	// The core finishes only a run in flight here, never on top of a fresh start
	a_done_in_run: assert property (@(posedge clk) disable iff (!rst_n)
		core_done |-> (busy && !start));

endmodule

// ==== hdl/div_core.sv ====
/*
 * Radix-2 restoring divider
 * Produces quotient and remainder one bit per clock for signed or
 * unsigned operands, with a fixed latency even on divide by zero.
 */

`timescale 1ns/1ps

module div_core #(
	parameter int WID = 32
) (
	input  logic           clk,
	input  logic           rst_n,
	input  logic           start,
	input  logic           signed_op,
	input  logic [WID-1:0] dividend,
	input  logic [WID-1:0] divisor,
	output logic [WID-1:0] q,
	output logic [WID-1:0] r,
	output logic           dbz,
	output logic           core_done
);

	// Counter wide enough to hold WID itself
	localparam int CW = $clog2(WID + 1);

	logic [CW-1:0]  count;
	// Quotient shifts in from the right as the dividend shifts out on the left
	logic [WID-1:0] quo;
	logic [WID-1:0] rem;
	logic [WID-1:0] dvs;
	logic           neg_q;
	logic           neg_r;
	logic           a_neg;
	logic           b_neg;
	logic [WID-1:0] a_mag;
	logic [WID-1:0] b_mag;
	logic [WID:0]   trial;
	logic [WID:0]   diff;

	// ==================================================
	// Operand magnitudes
	// ==================================================

	// Unsigned operations never see a sign
	assign a_neg = signed_op & dividend[WID-1];
	assign b_neg = signed_op & divisor[WID-1];
	assign a_mag = a_neg ? -dividend : dividend;
	assign b_mag = b_neg ? -divisor : divisor;

	// Shifted partial remainder with the next dividend bit, and the trial subtraction
	assign trial = {rem, quo[WID-1]};
	assign diff = trial - {1'b0, dvs};

	// ==================================================
	// Sequencing
	// ==================================================

	// Count is loaded on start and runs down once per iteration
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			count <= '0;
			core_done <= 1'b0;
		end
		else
		begin
			core_done <= 1'b0;
			if (start)
				count <= CW'(WID);
			else if (count != '0)
			begin
				count <= count - 1'b1;
				// The last iteration raises done for one cycle
				core_done <= (count == CW'(1));
			end
		end
	end

	// Datapath registers
	always_ff @(posedge clk)
	begin
		if (start)
		begin
			quo <= a_mag;
			rem <= '0;
			dvs <= b_mag;
			neg_q <= a_neg ^ b_neg;
			neg_r <= a_neg;
			dbz <= (divisor == '0);
		end
		else if (count != '0)
		begin
			// Keep the difference when it did not go negative
			if (!diff[WID])
			begin
				rem <= diff[WID-1:0];
				quo <= {quo[WID-2:0], 1'b1};
			end
			else
			begin
				rem <= trial[WID-1:0];
				quo <= {quo[WID-2:0], 1'b0};
			end
		end
	end

	// ==================================================
	// Sign fix-up
	// ==================================================

	// A zero divisor leaves the dividend magnitude in rem, so the signed
	// remainder comes back as the original dividend without extra logic.
	// Most-negative over minus one wraps back to most-negative here too
	assign q = dbz ? '1 : (neg_q ? -quo : quo);
	assign r = neg_r ? -rem : rem;

	// A new run only starts once the previous one has counted out
	a_start_idle: assert property (@(posedge clk) disable iff (!rst_n)
		start |-> (count == '0));

endmodule

// ==== hdl/div_result.sv ====
/*
 * Divide result stage
 * Picks quotient or remainder, assigns the fault cause and registers
 * the result with a one-cycle done pulse.
 */

`timescale 1ns/1ps

module div_result #(
	parameter int WID = 32
) (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             core_done,
	input  logic [WID-1:0]   q,
	input  logic [WID-1:0]   r,
	input  logic             core_dbz,
	input  div_pkg::div_op_t op,
	output logic [WID-1:0]   o,
	output logic             done,
	output logic             dbz,
	output div_pkg::cause_t  cause
);

	logic [WID-1:0]  res_d;
	div_pkg::cause_t cause_d;

	// ==================================================
	// Result select
	// ==================================================
	always_comb
	begin
		res_d = '0;
		cause_d = div_pkg::FLT_NONE;
		if (!op.is_div)
		begin
			// Outside the divide group the lane returns the filler pattern
			res_d = {(WID/16){div_pkg::FILL16}};
			cause_d = div_pkg::FLT_UNIMP;
		end
		else if (!op.legal)
			cause_d = div_pkg::FLT_UNIMP;
		else
		begin
			res_d = op.want_rem ? r : q;
			cause_d = core_dbz ? div_pkg::FLT_DBZ : div_pkg::FLT_NONE;
		end
	end

	// Output registers hold their value until the next run completes
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			o <= '0;
			done <= 1'b0;
			dbz <= 1'b0;
			cause <= div_pkg::FLT_NONE;
		end
		else
		begin
			done <= core_done;
			if (core_done)
			begin
				o <= res_d;
				cause <= cause_d;
				// Only a legal divide can report a zero divisor
				dbz <= (cause_d == div_pkg::FLT_DBZ);
			end
		end
	end

	// The cause must be a defined code whenever a result is presented
	a_cause_known: assert property (@(posedge clk) disable iff (!rst_n)
		done |-> !$isunknown(cause));

endmodule

// ==== hdl/div_unit.sv ====
/*
 * Integer divide functional unit
 * Issue, iterative core and result stages on a single clock.
 */

`timescale 1ns/1ps

module div_unit #(
	parameter int WID = 32
) (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                ld,
	input  div_pkg::div_instr_t ir,
	input  logic [WID-1:0]      a,
	input  logic [WID-1:0]      b,
	input  logic [WID-1:0]      imm,
	output logic [WID-1:0]      o,
	output logic                done,
	output logic                dbz,
	output div_pkg::cause_t     cause,
	output logic                busy
);

	// Issue to core
	logic             start;
	logic             signed_op;
	logic [WID-1:0]   dividend;
	logic [WID-1:0]   divisor;
	// Issue to result
	div_pkg::div_op_t op;
	// Core to result
	logic [WID-1:0]   q;
	logic [WID-1:0]   r;
	logic             core_dbz;
	logic             core_done;

	div_issue #(.WID(WID)) i_div_issue (
		.clk(clk), .rst_n(rst_n), .ld(ld), .ir(ir), .a(a), .b(b), .imm(imm),
		.core_done(core_done), .start(start), .signed_op(signed_op),
		.dividend(dividend), .divisor(divisor), .op(op), .busy(busy)
	);

	div_core #(.WID(WID)) i_div_core (
		.clk(clk), .rst_n(rst_n), .start(start), .signed_op(signed_op),
		.dividend(dividend), .divisor(divisor), .q(q), .r(r),
		.dbz(core_dbz), .core_done(core_done)
	);

	div_result #(.WID(WID)) i_div_result (
		.clk(clk), .rst_n(rst_n), .core_done(core_done), .q(q), .r(r),
		.core_dbz(core_dbz), .op(op), .o(o), .done(done), .dbz(dbz), .cause(cause)
	);

endmodule

// ==== bench/clk_gen.sv ====
/*
 * Testbench clock and reset
 * 100 ns clock, reset held low for the first four cycles.
 */

`timescale 1ns/1ps

module clk_gen (
	output logic clk,
	output logic rst_n
);

	initial
	begin
		clk = 1'b0;
		forever
			#50 clk = ~clk;
	end

	// Reset lets go on a falling edge, away from the sampling edge
	initial
	begin
		rst_n = 1'b0;
		repeat (4)
			@(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
	end

endmodule

// ==== bench/div_unit_tb.sv ====
/*
 * Testbench for the integer divide unit
 * Directed tests against a reference model, with latency checks.
 */

`timescale 1ns/1ps

module div_unit_tb #(
	parameter int WID = 32
);

	// Longest wait allowed for any event, in clock cycles
	localparam int TIMEOUT = WID + 20;

	logic                clk;
	logic                rst_n;
	logic                ld;
	div_pkg::div_instr_t ir;
	logic [WID-1:0]      a;
	logic [WID-1:0]      b;
	logic [WID-1:0]      imm;
	logic [WID-1:0]      o;
	logic                done;
	logic                dbz;
	div_pkg::cause_t     cause;
	logic                busy;

	clk_gen i_clk_gen (.clk(clk), .rst_n(rst_n));

	div_unit #(.WID(WID)) i_div_unit (
		.clk(clk), .rst_n(rst_n), .ld(ld), .ir(ir), .a(a), .b(b), .imm(imm),
		.o(o), .done(done), .dbz(dbz), .cause(cause), .busy(busy)
	);

	// ==================================================
	// Helpers
	// ==================================================

	// Random word of any width, built from 32-bit draws
	function automatic logic [WID-1:0] rand_word();
		logic [WID-1:0] w;
		int             i;
		w = '0;
		for (i = 0; i < WID; i += 32)
			w = (w << 32) | WID'($urandom);
		return w;
	endfunction

	// Random word that is never zero, usually small in magnitude and of either sign
	function automatic logic [WID-1:0] rand_nonzero();
		logic [WID-1:0] w;
		w = (rand_word() >> ($urandom % WID)) | WID'(1);
		// Half the draws are negated so signed runs see negative divisors too
		return (($urandom % 2) != 0) ? -w : w;
	endfunction

	function automatic logic [2:0] fn_of(input int k);
		case (k % 4)
		0: return div_pkg::FN_DIV;
		1: return div_pkg::FN_DIVU;
		2: return div_pkg::FN_REM;
		default: return div_pkg::FN_REMU;
		endcase
	endfunction

	function automatic div_pkg::div_instr_t make_ir(input logic [6:0] opc, input logic sel,
		input logic [2:0] fn);
		div_pkg::div_instr_t v;
		v.opcode = opc;
		v.imm_sel = sel;
		v.op3 = fn;
		// Reserved bits carry random filler since the unit ignores them
		v.rsvd = 5'($urandom);
		return v;
	endfunction

	task automatic check(input string name, input logic [63:0] exp, input logic [63:0] act);
		assert (act === exp)
		else
		begin
			$display("FAILED at %0t ns: %s expected %0h, got %0h", $time, name, exp, act);
			$display("test failed");
			$fatal(1);
		end
	endtask

	task automatic timed_out(input string what);
		$display("Timed out waiting for %s", what);
		$display("test failed");
		$fatal(1);
	endtask

	// ==================================================
	// Reference model
	// ==================================================

	// Truncating division on magnitudes, then the quotient sign from both operands
	// and the remainder sign from the dividend
	task automatic model(input div_pkg::div_instr_t op_ir, input logic [WID-1:0] x,
		input logic [WID-1:0] y, input logic [WID-1:0] z, output logic [WID-1:0] exp_o,
		output div_pkg::cause_t exp_cause, output logic exp_dbz);
		logic [WID-1:0] dvs;
		logic [WID-1:0] mx;
		logic [WID-1:0] my;
		logic           sgn;
		logic           rem;
		logic           legal;
		logic           nx;
		logic           ny;
		dvs = op_ir.imm_sel ? z : y;
		sgn = (op_ir.op3 == div_pkg::FN_DIV) || (op_ir.op3 == div_pkg::FN_REM);
		rem = (op_ir.op3 == div_pkg::FN_REM) || (op_ir.op3 == div_pkg::FN_REMU);
		legal = sgn || (op_ir.op3 == div_pkg::FN_DIVU) || (op_ir.op3 == div_pkg::FN_REMU);
		exp_o = '0;
		exp_cause = div_pkg::FLT_NONE;
		exp_dbz = 1'b0;
		if (op_ir.opcode != div_pkg::OP_DIV)
		begin
			// Every 16-bit lane of the filler reads DEAD
			exp_o = {(WID/16){16'hdead}};
			exp_cause = div_pkg::FLT_UNIMP;
		end
		else if (!legal)
			exp_cause = div_pkg::FLT_UNIMP;
		else if (dvs == '0)
		begin
			exp_o = rem ? x : '1;
			exp_cause = div_pkg::FLT_DBZ;
			exp_dbz = 1'b1;
		end
		else
		begin
			nx = sgn & x[WID-1];
			ny = sgn & dvs[WID-1];
			mx = nx ? -x : x;
			my = ny ? -dvs : dvs;
			if (rem)
				exp_o = nx ? -(mx % my) : (mx % my);
			else
				exp_o = (nx ^ ny) ? -(mx / my) : (mx / my);
		end
	endtask

	// ==================================================
	// Drive and wait
	// ==================================================

	// Loads one operation; returns on the falling edge after the sampling edge
	task automatic start_op(input div_pkg::div_instr_t op_ir, input logic [WID-1:0] x,
		input logic [WID-1:0] y, input logic [WID-1:0] z);
		int n;
		n = 0;
		while (busy && n < TIMEOUT)
		begin
			@(negedge clk);
			n++;
		end
		if (busy)
			timed_out("busy to fall");
		ir = op_ir;
		a = x;
		b = y;
		imm = z;
		ld = 1'b1;
		@(posedge clk);
		@(negedge clk);
		ld = 1'b0;
		// Operands are captured now, so the inputs may wander
		a = rand_word();
		b = rand_word();
		imm = rand_word();
	endtask

	// Counts rising edges, one per falling edge, until done shows up
	task automatic wait_done(inout int edges);
		while (!done && edges <= TIMEOUT)
		begin
			@(negedge clk);
			edges++;
		end
		if (!done)
			timed_out("done");
	endtask

	task automatic check_result(input int edges, input logic [WID-1:0] exp_o,
		input div_pkg::cause_t exp_cause, input logic exp_dbz);
		check("done latency", 64'(WID + 2), 64'(edges));
		check("o", 64'(exp_o), 64'(o));
		check("cause", 64'(exp_cause), 64'(cause));
		check("dbz", 64'(exp_dbz), 64'(dbz));
		check("busy", 64'(0), 64'(busy));
	endtask

	task automatic run_op(input div_pkg::div_instr_t op_ir, input logic [WID-1:0] x,
		input logic [WID-1:0] y, input logic [WID-1:0] z);
		logic [WID-1:0]  exp_o;
		div_pkg::cause_t exp_cause;
		logic            exp_dbz;
		int              edges;
		model(op_ir, x, y, z, exp_o, exp_cause, exp_dbz);
		start_op(op_ir, x, y, z);
		edges = 0;
		wait_done(edges);
		check_result(edges, exp_o, exp_cause, exp_dbz);
		// Done lasts one cycle only
		@(negedge clk);
		check("done", 64'(0), 64'(done));
	endtask

	// ==================================================
	// Tests
	// ==================================================

	task automatic test_reset_state();
		check("done", 64'(0), 64'(done));
		check("busy", 64'(0), 64'(busy));
		check("o", 64'(0), 64'(o));
		check("cause", 64'(div_pkg::FLT_NONE), 64'(cause));
	endtask

	task automatic test_random();
		int i;
		for (i = 0; i < 32; i++)
			run_op(make_ir(div_pkg::OP_DIV, 1'b0, fn_of(i)), rand_word(), rand_nonzero(),
				rand_word());
	endtask

	// b gets the complement of imm, or zero, so using it would show up
	task automatic test_imm();
		logic [WID-1:0] z;
		int             i;
		for (i = 0; i < 4; i++)
		begin
			z = rand_nonzero();
			run_op(make_ir(div_pkg::OP_DIV, 1'b1, fn_of(i)), rand_word(), ~z, z);
		end
		run_op(make_ir(div_pkg::OP_DIV, 1'b1, div_pkg::FN_DIVU), rand_word(), '0,
			rand_nonzero());
	endtask

	task automatic test_dbz();
		int i;
		for (i = 0; i < 4; i++)
			run_op(make_ir(div_pkg::OP_DIV, 1'b0, fn_of(i)), rand_word(), '0, rand_word());
		// Zero immediate while the register divisor is not zero
		run_op(make_ir(div_pkg::OP_DIV, 1'b1, div_pkg::FN_REM), rand_word(), WID'(1), '0);
	endtask

	task automatic test_special();
		logic [WID-1:0] mneg;
		int             i;
		mneg = {1'b1, {(WID-1){1'b0}}};
		run_op(make_ir(div_pkg::OP_DIV, 1'b0, div_pkg::FN_DIV), mneg, '1, '0);
		run_op(make_ir(div_pkg::OP_DIV, 1'b0, div_pkg::FN_REM), mneg, '1, '0);
		for (i = 0; i < 4; i++)
			run_op(make_ir(div_pkg::OP_DIV, 1'b0, fn_of(i)), '0, rand_nonzero(), '0);
	endtask

	task automatic test_illegal();
		int i;
		run_op(make_ir(~div_pkg::OP_DIV, 1'b0, div_pkg::FN_DIV), rand_word(),
			rand_nonzero(), '0);
		// Function codes 2, 3, 6 and 7 are unused; the last one has a zero divisor
		for (i = 0; i < 4; i++)
			run_op(make_ir(div_pkg::OP_DIV, 1'b0, (i < 2) ? 3'(i + 2) : 3'(i + 4)),
				rand_word(), (i == 3) ? '0 : rand_nonzero(), '0);
	endtask

	// A second load in the middle of a run must leave no trace
	task automatic test_busy_ignore();
		div_pkg::div_instr_t op_ir;
		logic [WID-1:0]      x;
		logic [WID-1:0]      y;
		logic [WID-1:0]      exp_o;
		div_pkg::cause_t     exp_cause;
		logic                exp_dbz;
		int                  edges;
		int                  i;
		op_ir = make_ir(div_pkg::OP_DIV, 1'b0, div_pkg::FN_DIVU);
		x = rand_word();
		y = rand_nonzero();
		model(op_ir, x, y, '0, exp_o, exp_cause, exp_dbz);
		start_op(op_ir, x, y, '0);
		edges = 0;
		repeat (3)
		begin
			@(negedge clk);
			edges++;
		end
		check("busy", 64'(1), 64'(busy));
		ir = make_ir(div_pkg::OP_DIV, 1'b0, div_pkg::FN_REM);
		a = rand_word();
		b = rand_nonzero();
		ld = 1'b1;
		@(negedge clk);
		edges++;
		ld = 1'b0;
		wait_done(edges);
		check_result(edges, exp_o, exp_cause, exp_dbz);
		for (i = 0; i < WID + 4; i++)
		begin
			@(negedge clk);
			check("done", 64'(0), 64'(done));
		end
		check("busy", 64'(0), 64'(busy));
	endtask

	// ==================================================
	// Main sequence
	// ==================================================
	initial
	begin
		int n;
		ld = 1'b0;
		ir = '0;
		a = '0;
		b = '0;
		imm = '0;
		void'($urandom(32'h27b701bf));
		n = 0;
		while (rst_n !== 1'b1 && n < TIMEOUT)
		begin
			@(negedge clk);
			n++;
		end
		if (rst_n !== 1'b1)
			timed_out("reset release");
		test_reset_state();
		test_random();
		test_imm();
		test_dbz();
		test_special();
		test_illegal();
		test_busy_ignore();
		$display("test passed");
		$finish;
	end

endmodule

// ==== vlog.f ====
hdl/div_pkg.sv
hdl/div_issue.sv
hdl/div_core.sv
hdl/div_result.sv
hdl/div_unit.sv
bench/clk_gen.sv
bench/div_unit_tb.sv

// ==== Makefile ====
# Verilator lint and simulation of the divide unit

VERILATOR ?= verilator
TOP       ?= div_unit_tb
WID       ?= 32
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir
FLIST     ?= vlog.f

VFLAGS = --sv --timing --assert -f $(FLIST) --top-module $(TOP) -GWID=$(WID)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS)

# The run itself may stop with an error; the log decides pass or fail
sim:
	$(VERILATOR) --binary $(VFLAGS) -Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "test passed" $(LOG) || (echo "Simulation did not pass, see $(LOG)" && exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
